// File: rtl/pe_array_pkg.sv
/*
 * Shared sizes and word formats of the sparse convolution PE array.
 * Every RTL module and the testbench import this package.
 * NUM_PEB and LEN_PSUM are only defaults; the top level may override them.
 */
`default_nettype none

package pe_array_pkg;

    // ====================
    // Array sizes
    // ====================

    // Signed width of one activation or weight value
    localparam int DATA_WIDTH  = 8;
    // Lanes per activation word and per weight vector
    localparam int BLOCK_DEPTH = 4;
    // Default chain length and buffer depth
    localparam int NUM_PEB     = 4;
    localparam int LEN_PSUM    = 8;

    // Full product, lane-sum growth, plus 2 bits of accumulation headroom
    localparam int PSUM_WIDTH  = 2 * DATA_WIDTH + $clog2(BLOCK_DEPTH) + 2;

    // ====================
    // Word formats
    // ====================

    // Activation word as it hops along the chain (38 bits)
    typedef struct packed {
        logic                                    frt_blk;      // Overwrite instead of add
        logic                                    lst_act_blk;  // Last word, address back to 0
        logic [BLOCK_DEPTH-1:0]                  flg;          // Lane holds a nonzero value
        logic [BLOCK_DEPTH-1:0][DATA_WIDTH-1:0]  dat;
    } act_word_t;

    // Weight vector on the shared weight bus (36 bits)
    typedef struct packed {
        logic [BLOCK_DEPTH-1:0]                  flg;
        logic [BLOCK_DEPTH-1:0][DATA_WIDTH-1:0]  dat;
    } wei_word_t;

    // One partial-sum buffer entry
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

endpackage

`default_nettype wire

// File: rtl/act_stage.sv
/*
 * Single-entry hop register of the activation chain.
 * Upstream and downstream both use the rdy/get pair: a word moves in
 * any cycle where rdy and get are high. Accepts only while enable is set.
 */
`default_nettype none

module act_stage
    import pe_array_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    // Upstream side
    input  wire act_word_t lst_act,
    input  wire logic      lst_rdy,
    output logic           lst_get,
    // Weight held by the owning block
    input  wire logic      enable,
    // Downstream side
    output act_word_t      nxt_act,
    output logic           nxt_rdy,
    input  wire logic      nxt_get
);

    // ====================
    // Storage
    // ====================

    logic      full;
    act_word_t act_q;
    logic      take;

    // Room when empty, or when the held word leaves this cycle
    assign lst_get = enable && (!full || nxt_get);
    assign take    = lst_rdy && lst_get;

    // Held word is offered downstream from the cycle after acceptance
    assign nxt_act = act_q;
    assign nxt_rdy = full;

    // Occupancy flag
    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (nxt_get) begin
            // Drained with nothing new behind it
            full <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (take) begin
            act_q <= lst_act;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pe_block.sv
/*
 * One processing block of the chain.
 * Fetches a weight vector over the shared weight bus and keeps it until
 * the frame ends. Every activation word it accepts produces a flag-gated
 * dot product that is written or added into the partial-sum buffer at
 * the running address. The pooling side reads the buffer by address.
 */
`default_nettype none

module pe_block
    import pe_array_pkg::*;
#(
    parameter int LEN_PSUM = pe_array_pkg::LEN_PSUM
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    // Activation chain, upstream
    input  wire act_word_t                   lst_act,
    input  wire logic                        lst_rdy,
    output logic                             lst_get,
    // Activation chain, downstream
    output act_word_t                        nxt_act,
    output logic                             nxt_rdy,
    input  wire logic                        nxt_get,
    // Weight bus
    input  wire wei_word_t                   wei,
    input  wire logic                        wei_rdy,
    output logic                             wei_get,
    // End of frame, drop the held weight
    input  wire logic                        fnh_frm,
    // Pooling read port
    input  wire logic [$clog2(LEN_PSUM)-1:0] rd_addr,
    output psum_t                            rd_dat
);

    localparam int ADDR_WIDTH = $clog2(LEN_PSUM);

    // ====================
    // Weight capture
    // ====================

    logic      wei_hold;
    wei_word_t wei_q;

    // One-cycle get pulse, registered so it never follows wei_rdy
    // through reset
    always_ff @(posedge clk) begin
        if (reset) begin
            wei_get <= 1'b0;
        end else begin
            wei_get <= wei_rdy && !wei_hold && !wei_get;
        end
    end

    // Held state, set at the end of the pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            wei_hold <= 1'b0;
        end else if (wei_get) begin
            wei_hold <= 1'b1;
        end else if (fnh_frm) begin
            wei_hold <= 1'b0;
        end
    end

    // Bus is sampled in the pulse cycle
    always_ff @(posedge clk) begin
        if (wei_get) begin
            wei_q <= wei;
        end
    end

    // ====================
    // Activation hop
    // ====================

    logic act_fire;

    act_stage u_act_stage (
        .clk     (clk),
        .reset   (reset),
        .lst_act (lst_act),
        .lst_rdy (lst_rdy),
        .lst_get (lst_get),
        .enable  (wei_hold),
        .nxt_act (nxt_act),
        .nxt_rdy (nxt_rdy),
        .nxt_get (nxt_get)
    );

    // Word accepted by this block's stage in this cycle
    assign act_fire = lst_rdy && lst_get;

    // ====================
    // Gated dot product
    // ====================

    psum_t prod_sum;

    always_comb begin
        logic signed [2*DATA_WIDTH-1:0] prod;
        prod_sum = '0;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            prod = $signed(lst_act.dat[i]) * $signed(wei_q.dat[i]);
            // Zero skip, a lane counts only with both flags set
            if (lst_act.flg[i] && wei_q.flg[i]) begin
                prod_sum = prod_sum + prod;
            end
        end
    end

    // ====================
    // Address and buffer
    // ====================

    logic [ADDR_WIDTH-1:0] addr;
    psum_t                 psum_mem [LEN_PSUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            addr <= '0;
        end else if (act_fire) begin
            if (lst_act.lst_act_blk || addr == ADDR_WIDTH'(LEN_PSUM - 1)) begin
                addr <= '0;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    // First block of the frame overwrites, later blocks accumulate
    always_ff @(posedge clk) begin
        if (act_fire) begin
            if (lst_act.frt_blk) begin
                psum_mem[addr] <= prod_sum;
            end else begin
                psum_mem[addr] <= psum_mem[addr] + prod_sum;
            end
        end
    end

    assign rd_dat = psum_mem[rd_addr];

endmodule

`default_nettype wire

// File: rtl/psum_read_mux.sv
/*
 * Pooling read mux. Broadcasts the entry address to every block and
 * registers the entry of the block picked by pool_sel.
 * A pool_sel of NUM_PEB or more returns zero.
 */
`default_nettype none

module psum_read_mux
    import pe_array_pkg::*;
#(
    parameter int NUM_PEB  = pe_array_pkg::NUM_PEB,
    parameter int LEN_PSUM = pe_array_pkg::LEN_PSUM
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic [$clog2(NUM_PEB):0]    pool_sel,
    input  wire logic [$clog2(LEN_PSUM)-1:0] pool_addr,
    input  wire psum_t                       blk_dat [NUM_PEB],
    output psum_t                            pool_dat,
    output logic [$clog2(LEN_PSUM)-1:0]      rd_addr
);

    localparam int SEL_WIDTH = $clog2(NUM_PEB) + 1;

    // Same address to all buffers
    assign rd_addr = pool_addr;

    // ====================
    // Output register
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            pool_dat <= '0;
        end else if (pool_sel < SEL_WIDTH'(NUM_PEB)) begin
            pool_dat <= blk_dat[pool_sel[SEL_WIDTH-2:0]];
        end else begin
            pool_dat <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pe_array_top.sv
/*
 * Top of the PE array: NUM_PEB processing blocks in an activation chain
 * with a shared weight bus, and the pooling read mux.
 * Words leave the array after the last block.
 */
`default_nettype none

module pe_array_top
    import pe_array_pkg::*;
#(
    parameter int NUM_PEB  = pe_array_pkg::NUM_PEB,
    parameter int LEN_PSUM = pe_array_pkg::LEN_PSUM
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    // Activation source
    input  wire act_word_t                   act_in,
    input  wire logic                        act_rdy,
    output logic                             act_get,
    // Weight source, one request bit per block
    input  wire wei_word_t                   wei,
    input  wire logic [NUM_PEB-1:0]          wei_rdy,
    output logic [NUM_PEB-1:0]               wei_get,
    input  wire logic                        fnh_frm,
    // Pooling read
    input  wire logic [$clog2(NUM_PEB):0]    pool_sel,
    input  wire logic [$clog2(LEN_PSUM)-1:0] pool_addr,
    output psum_t                            pool_dat
);

    // ====================
    // Chain links
    // ====================

    // Link j feeds block j, link NUM_PEB is the array exit
    act_word_t                   chain_act [NUM_PEB+1];
    logic [NUM_PEB:0]            chain_rdy;
    logic [NUM_PEB:0]            chain_get;
    psum_t                       blk_dat   [NUM_PEB];
    logic [$clog2(LEN_PSUM)-1:0] rd_addr;

    assign chain_act[0]       = act_in;
    assign chain_rdy[0]       = act_rdy;
    assign act_get            = chain_get[0];
    // Nothing downstream of the last block
    assign chain_get[NUM_PEB] = 1'b1;

    for (genvar i = 0; i < NUM_PEB; i++) begin : g_peb
        pe_block #(
            .LEN_PSUM (LEN_PSUM)
        ) u_pe_block (
            .clk     (clk),
            .reset   (reset),
            .lst_act (chain_act[i]),
            .lst_rdy (chain_rdy[i]),
            .lst_get (chain_get[i]),
            .nxt_act (chain_act[i+1]),
            .nxt_rdy (chain_rdy[i+1]),
            .nxt_get (chain_get[i+1]),
            .wei     (wei),
            .wei_rdy (wei_rdy[i]),
            .wei_get (wei_get[i]),
            .fnh_frm (fnh_frm),
            .rd_addr (rd_addr),
            .rd_dat  (blk_dat[i])
        );
    end

    // ====================
    // Pooling read
    // ====================

    psum_read_mux #(
        .NUM_PEB  (NUM_PEB),
        .LEN_PSUM (LEN_PSUM)
    ) u_psum_read_mux (
        .clk       (clk),
        .reset     (reset),
        .pool_sel  (pool_sel),
        .pool_addr (pool_addr),
        .blk_dat   (blk_dat),
        .pool_dat  (pool_dat),
        .rd_addr   (rd_addr)
    );

endmodule

`default_nettype wire

// File: sim/pe_array_properties.sv
/*
 * Concurrent checks on the PE array handshakes and reset state.
 * Bound into pe_array_top, so it watches the top-level ports directly.
 */
`default_nettype none

module pe_array_properties
    import pe_array_pkg::*;
#(
    parameter int NUM_PEB = pe_array_pkg::NUM_PEB
) (
    input wire logic               clk,
    input wire logic               reset,
    input wire act_word_t          act_in,
    input wire logic               act_rdy,
    input wire logic               act_get,
    input wire logic [NUM_PEB-1:0] wei_rdy,
    input wire logic [NUM_PEB-1:0] wei_get
);
    timeunit 1ns;
    timeprecision 1ps;

    // ====================
    // Activation source
    // ====================

    // Offered word stays put until block 0 takes it
    act_hold: assert property (@(posedge clk) disable iff (reset)
        act_rdy && !act_get |=> act_rdy && $stable(act_in))
        else $error("act_in changed or act_rdy dropped before act_get");

    // ====================
    // Reset state
    // ====================

    reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !act_get && wei_get == '0)
        else $error("act_get or wei_get high during reset");

    // First two cycles after reset
    reset_exit: assert property (@(posedge clk)
        $fell(reset) |-> (!act_get && wei_get == '0) ##1 (!act_get && wei_get == '0))
        else $error("act_get or wei_get high right after reset");

    // ====================
    // Weight handshake
    // ====================

    for (genvar j = 0; j < NUM_PEB; j++) begin : g_wei
        // Pulse only against a live request
        wei_needs_rdy: assert property (@(posedge clk) disable iff (reset)
            wei_get[j] |-> wei_rdy[j])
            else $error("wei_get without wei_rdy on block %0d", j);

        // Exactly one single-cycle pulse per request
        wei_one_pulse: assert property (@(posedge clk) disable iff (reset)
            $rose(wei_rdy[j]) |-> !wei_get[j] ##1 wei_get[j] ##1
                (!wei_get[j] && !wei_rdy[j]))
            else $error("wei_get did not pulse once for block %0d", j);
    end

endmodule

bind pe_array_top pe_array_properties #(
    .NUM_PEB (NUM_PEB)
) u_pe_array_properties (
    .clk     (clk),
    .reset   (reset),
    .act_in  (act_in),
    .act_rdy (act_rdy),
    .act_get (act_get),
    .wei_rdy (wei_rdy),
    .wei_get (wei_get)
);

`default_nettype wire

// File: sim/pe_array_tb.sv
/*
 * Self-checking testbench of the PE array.
 * Loads weights, streams a dense pass, a sparse pass and a new frame,
 * then reads every partial-sum entry back and compares it with a model.
 * Built and run by run_sim.sh.
 */
`default_nettype none

module pe_array_tb
    import pe_array_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_BLK      = 4;
    localparam int          PSUM_DEPTH   = 8;
    localparam int          SEL_W        = $clog2(NUM_BLK) + 1;
    localparam int          ADDR_W       = $clog2(PSUM_DEPTH);
    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 10;
    localparam int          MAX_GAP      = 2;
    localparam logic [31:0] SEED         = 32'h2251;
    // Cycle budget per phase
    localparam int LOAD_CYCLES = NUM_BLK * 4 + 8;
    localparam int PASS_CYCLES = LOAD_CYCLES + PSUM_DEPTH * (MAX_GAP + 3) + 2 * NUM_BLK;
    localparam int READ_CYCLES = (NUM_BLK + 1) * PSUM_DEPTH * 2 + 2 * NUM_BLK;
    localparam int RUN_CYCLES  = RESET_CYCLES + 3 * (PASS_CYCLES + READ_CYCLES) + 200;

    logic               clk = 1'b0;
    logic               reset;
    act_word_t          act_in;
    logic               act_rdy;
    logic               act_get;
    wei_word_t          wei;
    logic [NUM_BLK-1:0] wei_rdy;
    logic [NUM_BLK-1:0] wei_get;
    logic               fnh_frm;
    logic [SEL_W-1:0]   pool_sel;
    logic [ADDR_W-1:0]  pool_addr;
    psum_t              pool_dat;

    // Reference model state
    logic [31:0] rng_state;
    wei_word_t   wei_model [NUM_BLK];
    longint      exp_psum  [NUM_BLK][PSUM_DEPTH];
    int          model_addr;
    act_word_t   sent_q [$];

    pe_array_top #(
        .NUM_PEB  (NUM_BLK),
        .LEN_PSUM (PSUM_DEPTH)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .act_in    (act_in),
        .act_rdy   (act_rdy),
        .act_get   (act_get),
        .wei       (wei),
        .wei_rdy   (wei_rdy),
        .wei_get   (wei_get),
        .fnh_frm   (fnh_frm),
        .pool_sel  (pool_sel),
        .pool_addr (pool_addr),
        .pool_dat  (pool_dat)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Lane counts only with both flags set
    function automatic longint gated_dot(input act_word_t a, input wei_word_t w);
        longint sum;
        sum = 0;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            if (a.flg[i] && w.flg[i]) begin
                sum += longint'($signed(a.dat[i])) * longint'($signed(w.dat[i]));
            end
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input longint got, input longint exp);
        assert (got == exp) else begin
            $display("FAILED time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Every block sees every word in the same order, so one address serves all
    task automatic update_model();
        act_word_t a;
        while (sent_q.size() > 0) begin
            a = sent_q.pop_front();
            for (int j = 0; j < NUM_BLK; j++) begin
                if (a.frt_blk) begin
                    exp_psum[j][model_addr] = gated_dot(a, wei_model[j]);
                end else begin
                    exp_psum[j][model_addr] += gated_dot(a, wei_model[j]);
                end
            end
            if (a.lst_act_blk || model_addr == PSUM_DEPTH - 1) begin
                model_addr = 0;
            end else begin
                model_addr++;
            end
        end
    endtask

    // ====================
    // Stimulus
    // ====================

    task automatic load_weight(input int j);
        wei_word_t w;
        w.dat        = (BLOCK_DEPTH * DATA_WIDTH)'(next_random());
        w.flg        = BLOCK_DEPTH'(next_random());
        wei_model[j] = w;
        wei        <= w;
        wei_rdy[j] <= 1'b1;
        do begin
            @(posedge clk);
            // Chain holds off while block 0 has no weight
            if (j == 0) begin
                check_value("act_get", act_get, 0);
            end
        end while (!wei_get[j]);
        wei_rdy[j] <= 1'b0;
    endtask

    task automatic load_weights();
        repeat (4) begin
            @(posedge clk);
            check_value("act_get", act_get, 0);
        end
        for (int j = 0; j < NUM_BLK; j++) begin
            load_weight(j);
        end
    endtask

    task automatic send_pass(input logic frt, input logic sparse, input int count);
        act_word_t a;
        int        gap;
        for (int k = 0; k < count; k++) begin
            a.dat         = (BLOCK_DEPTH * DATA_WIDTH)'(next_random());
            a.flg         = sparse ? BLOCK_DEPTH'(next_random()) : '1;
            a.frt_blk     = frt;
            a.lst_act_blk = (k == count - 1);
            gap           = sparse ? int'(next_random() % (MAX_GAP + 1)) : 0;
            // Idle cycles with act_rdy low
            if (gap > 0) begin
                act_rdy <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            act_in  <= a;
            act_rdy <= 1'b1;
            do begin
                @(posedge clk);
            end while (!act_get);
            sent_q.push_back(a);
        end
        act_rdy <= 1'b0;
    endtask

    // Reads every block and entry, plus one block index out of range
    task automatic check_buffers();
        longint expected;
        update_model();
        repeat (2 * NUM_BLK) @(posedge clk);
        for (int s = 0; s <= NUM_BLK; s++) begin
            for (int r = 0; r < PSUM_DEPTH; r++) begin
                pool_sel  <= SEL_W'(s);
                pool_addr <= ADDR_W'(r);
                repeat (2) @(posedge clk);
                expected = (s < NUM_BLK) ? exp_psum[s][r] : 0;
                check_value($sformatf("pool_dat[%0d][%0d]", s, r), pool_dat, expected);
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        rng_state  = SEED;
        model_addr = 0;
        reset      = 1'b1;
        act_in     = '0;
        act_rdy    = 1'b0;
        wei        = '0;
        wei_rdy    = '0;
        fnh_frm    = 1'b0;
        pool_sel   = '0;
        pool_addr  = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("act_get", act_get, 0);
        check_value("wei_get", wei_get, 0);
        check_value("pool_dat", pool_dat, 0);

        // Weight load with a dense first pass waiting behind it
        fork
            load_weights();
            send_pass(1'b1, 1'b0, PSUM_DEPTH);
        join
        check_buffers();

        // Sparse pass shorter than the buffer on top of the first sums
        // The next pass only starts at entry 0 through lst_act_blk
        send_pass(1'b0, 1'b1, PSUM_DEPTH - 2);
        check_buffers();

        // New frame drops every weight
        fnh_frm <= 1'b1;
        @(posedge clk);
        fnh_frm <= 1'b0;
        fork
            load_weights();
            send_pass(1'b1, 1'b1, PSUM_DEPTH);
        join
        check_buffers();

        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", RUN_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

// File: src.f
rtl/pe_array_pkg.sv
rtl/act_stage.sv
rtl/pe_block.sv
rtl/psum_read_mux.sv
rtl/pe_array_top.sv
sim/pe_array_properties.sv
sim/pe_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the PE array testbench with Verilator and runs it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pe_array_tb \
    --Mdir obj_dir -o pe_array_sim \
    -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/pe_array_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
fi
exit "$status"
